//--- flist.f
+incdir+verif
rtl/udp_tx_pkg.sv
rtl/udp_tx_ifs.sv
rtl/tx_tick_gen.sv
rtl/udp_frame_builder.sv
rtl/eth_fcs_crc32.sv
rtl/mii_tx_sequencer.sv
rtl/udp_eth_tx.sv
verif/tb_clock_gen.sv
verif/udp_eth_tx_tb.sv

//--- verif/tb_frame_model.svh
`ifndef TB_FRAME_MODEL_SVH
`define TB_FRAME_MODEL_SVH

// Reference model of the transmitted frame, worked out octet by octet
// Uses the stimulus table, exp_octets and fill_pos of the including testbench

// IPv4 header checksum over the ten header words with the checksum word at zero
function automatic logic [15:0] ip_checksum(input ip_addr_t src, input ip_addr_t dst);
    logic [15:0] words [10];
    logic [16:0] acc;
    words[0] = 16'h450C;
    words[1] = 16'(28 + DATA_BYTES);
    words[2] = 16'h0000;
    words[3] = 16'h0000;
    words[4] = 16'hFF11;
    words[5] = 16'h0000;
    words[6] = src[31:16];
    words[7] = src[15:0];
    words[8] = dst[31:16];
    words[9] = dst[15:0];
    acc = '0;
    for (int i = 0; i < 10; i++) begin
        acc = 17'(acc[15:0]) + 17'(words[i]);
        // End-around carry after every word
        acc = 17'(acc[15:0]) + 17'(acc[16]);
    end
    return ~acc[15:0];
endfunction

// Bitwise CRC-32 step over one octet, bit 0 first as on the wire
function automatic crc_t crc32_byte(input crc_t crc_in, input octet_t data);
    crc_t c;
    c = crc_in ^ {24'h0, data};
    for (int b = 0; b < 8; b++) begin
        if (c[0]) begin
            c = (c >> 1) ^ 32'hEDB88320;
        end else begin
            c = c >> 1;
        end
    end
    return c;
endfunction

// Appends a field to the expected frame, most significant octet first
task automatic add_field(input logic [47:0] value, input int bytes);
    for (int i = bytes - 1; i >= 0; i--) begin
        exp_octets[fill_pos] = value[8*i +: 8];
        fill_pos++;
    end
endtask

// Fills exp_octets with headers, payload and FCS for table entry t
task automatic build_expected_frame(input int t);
    crc_t crc;
    exp_csum_tab[t] = ip_checksum(src_ip_tab[t], dest_ip_tab[t]);
    fill_pos = 0;
    add_field(dest_mac_tab[t], 6);
    add_field(src_mac_tab[t], 6);
    add_field(48'h0800, 2);
    add_field(48'h450C, 2);
    add_field(48'(28 + DATA_BYTES), 2);
    // Identification, flags and fragment offset
    add_field(48'h0, 4);
    add_field(48'hFF11, 2);
    add_field(48'(exp_csum_tab[t]), 2);
    add_field(48'(src_ip_tab[t]), 4);
    add_field(48'(dest_ip_tab[t]), 4);
    add_field(48'(src_port_tab[t]), 2);
    add_field(48'(dest_port_tab[t]), 2);
    add_field(48'(8 + DATA_BYTES), 2);
    add_field(48'h0, 2);
    for (int b = DATA_BYTES - 1; b >= 0; b--) begin
        exp_octets[fill_pos] = payload_tab[t][8*b +: 8];
        fill_pos++;
    end
    crc = 32'hFFFFFFFF;
    for (int i = 0; i < fill_pos; i++) begin
        crc = crc32_byte(crc, exp_octets[i]);
    end
    crc = ~crc;
    exp_fcs_tab[t] = crc;
    // FCS goes out least significant octet first
    for (int i = 0; i < 4; i++) begin
        exp_octets[fill_pos] = crc[8*i +: 8];
        fill_pos++;
    end
endtask

`endif

//--- verif/udp_eth_tx_tb.sv
`default_nettype none

// Testbench for the UDP over IPv4 MII transmitter
module udp_eth_tx_tb import udp_tx_pkg::*; ();

    localparam int DATA_BYTES = 18;
    localparam int DIVIDER = 4;
    localparam int NUM_TESTS = 4;
    localparam int DRIVE_DELAY = 2;
    localparam int FRAME_OCTETS = FRAME_HEADER_BYTES + DATA_BYTES + FCS_BYTES;
    localparam int WIRE_NIBBLES = PREAMBLE_NIBBLES + 2 * FRAME_OCTETS;
    localparam int FRAME_TICKS = 16 + 2 * (46 + DATA_BYTES) + 24;
    // Twice the ticks of all frames, counted in clk cycles
    localparam int TIMEOUT_CYCLES = NUM_TESTS * FRAME_TICKS * DIVIDER * 2;
    localparam int RX_DEPTH = NUM_TESTS * WIRE_NIBBLES + 16;

    logic clk;
    logic reset;
    logic send;
    logic [8*DATA_BYTES-1:0] payload;
    mac_addr_t src_mac;
    mac_addr_t dest_mac;
    ip_addr_t src_ip;
    ip_addr_t dest_ip;
    udp_port_t src_port;
    udp_port_t dest_port;
    logic ready;
    logic tx_en;
    nibble_t tx_d;

    // Stimulus table, one column per field; payloads are filled from $random
    mac_addr_t dest_mac_tab [NUM_TESTS] = '{48'h021122334455, 48'hFFFFFFFFFFFF,
        48'h001B2C3D4E5F, 48'h3CFDFE000102};
    mac_addr_t src_mac_tab [NUM_TESTS] = '{48'h02AABBCCDDEE, 48'h020000000001,
        48'h00A0C9112233, 48'h0E0D0C0B0A09};
    ip_addr_t src_ip_tab [NUM_TESTS] = '{32'hC0A80001, 32'h0A000001, 32'hAC100A01, 32'h7F000001};
    ip_addr_t dest_ip_tab [NUM_TESTS] = '{32'hC0A80064, 32'h0A0000FF, 32'hAC101402, 32'hE0000001};
    udp_port_t src_port_tab [NUM_TESTS] = '{16'h1234, 16'h0400, 16'hC350, 16'hFFFF};
    udp_port_t dest_port_tab [NUM_TESTS] = '{16'h5678, 16'h0035, 16'h1F90, 16'h0001};
    // Entries with a second send pulse while the frame is still going out
    logic extra_send_tab [NUM_TESTS] = '{1'b0, 1'b1, 1'b0, 1'b1};
    logic [8*DATA_BYTES-1:0] payload_tab [NUM_TESTS];

    // Expected columns, filled in by the model
    logic [15:0] exp_csum_tab [NUM_TESTS];
    crc_t exp_fcs_tab [NUM_TESTS];
    octet_t exp_octets [FRAME_OCTETS];
    int fill_pos;

    nibble_t rx_nibbles [RX_DEPTH];
    int rx_count = 0;
    int rx_phase = 0;
    int frames_seen = 0;
    logic tx_en_prev = 1'b0;
    int cycle_count = 0;
    int check_count = 0;
    int error_count = 0;

    `include "tb_frame_model.svh"

    tb_clock_gen #(
        .PERIOD(40)
    ) u_clock (
        .clk(clk)
    );

    udp_eth_tx #(
        .DATA_BYTES(DATA_BYTES),
        .DIVIDER(DIVIDER)
    ) dut (
        .clk(clk),
        .reset(reset),
        .send(send),
        .payload(payload),
        .src_mac(src_mac),
        .dest_mac(dest_mac),
        .src_ip(src_ip),
        .dest_ip(dest_ip),
        .src_port(src_port),
        .dest_port(dest_port),
        .ready(ready),
        .tx_en(tx_en),
        .tx_d(tx_d)
    );

    // Nibbles hold for DIVIDER cycles, so take one every DIVIDER falling edges
    // A frame is counted when tx_en rises, so a stray frame shows up right away
    always @(negedge clk) begin
        if (tx_en === 1'b1) begin
            if (!tx_en_prev) begin
                frames_seen++;
            end
            if (rx_phase == 0) begin
                if (rx_count < RX_DEPTH) begin
                    rx_nibbles[rx_count] = tx_d;
                end
                rx_count++;
            end
            rx_phase = (rx_phase + 1) % DIVIDER;
        end else begin
            rx_phase = 0;
        end
        tx_en_prev = (tx_en === 1'b1);
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the DUT did not finish all frames within %0d cycles",
                TIMEOUT_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("error: %s got 0x%0h expected 0x%0h", name, got, expected);
        end
    endtask

    task automatic note_failure(input string what);
        check_count++;
        error_count++;
        $display("%s", what);
    endtask

    // Compares the nibbles captured from base on against the model
    task automatic check_frame(input int t, input int base);
        octet_t got [FRAME_OCTETS];
        logic [16:0] sum;
        check_value("tx_d nibble count", 32'(rx_count - base), 32'(WIRE_NIBBLES));
        if (rx_count - base == WIRE_NIBBLES) begin
            for (int i = 0; i < PREAMBLE_NIBBLES - 1; i++) begin
                check_value($sformatf("tx_d preamble %0d", i), 32'(rx_nibbles[base + i]), 32'h5);
            end
            check_value("tx_d sfd", 32'(rx_nibbles[base + PREAMBLE_NIBBLES - 1]), 32'hD);
            // Low nibble arrives first within each octet
            for (int i = 0; i < FRAME_OCTETS; i++) begin
                got[i] = {rx_nibbles[base + PREAMBLE_NIBBLES + 2*i + 1],
                    rx_nibbles[base + PREAMBLE_NIBBLES + 2*i]};
                check_value($sformatf("tx_d octet %0d", i), 32'(got[i]), 32'(exp_octets[i]));
            end
            // A correct IPv4 header sums to all ones
            sum = '0;
            for (int i = 0; i < 10; i++) begin
                sum = 17'(sum[15:0]) + 17'({got[14 + 2*i], got[15 + 2*i]});
                sum = 17'(sum[15:0]) + 17'(sum[16]);
            end
            check_value("ip header sum", 32'(sum[15:0]), 32'hFFFF);
            check_value("ip checksum", 32'({got[24], got[25]}), 32'(exp_csum_tab[t]));
            check_value("fcs", {got[63], got[62], got[61], got[60]}, exp_fcs_tab[t]);
        end
    endtask

    initial begin : stimulus
        int seed;
        int base;
        int n;
        int fall_cycle;
        int errors_before;
        int checks_before;
        logic en_seen;
        seed = 32'h319e;
        reset = 1'b1;
        send = 1'b0;
        payload = '0;
        src_mac = '0;
        dest_mac = '0;
        src_ip = '0;
        dest_ip = '0;
        src_port = '0;
        dest_port = '0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            for (int b = 0; b < DATA_BYTES; b++) begin
                payload_tab[t][8*b +: 8] = 8'($random(seed));
            end
        end
        repeat (5) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        next_cycle();
        check_value("ready", 32'(ready), 32'h1);
        for (int t = 0; t < NUM_TESTS; t++) begin
            errors_before = error_count;
            checks_before = check_count;
            build_expected_frame(t);
            base = rx_count;
            dest_mac = dest_mac_tab[t];
            src_mac = src_mac_tab[t];
            src_ip = src_ip_tab[t];
            dest_ip = dest_ip_tab[t];
            src_port = src_port_tab[t];
            dest_port = dest_port_tab[t];
            payload = payload_tab[t];
            send = 1'b1;
            next_cycle();
            send = 1'b0;
            check_value("ready", 32'(ready), 32'h0);
            n = 0;
            en_seen = 1'b0;
            fall_cycle = -1;
            // Follow the frame until ready returns, noting where tx_en drops
            while (ready !== 1'b1) begin
                next_cycle();
                n++;
                send = extra_send_tab[t] && (n == 20 || n == 21);
                if (send) begin
                    // A refused request offers other data, which must not reach the frame
                    payload = ~payload_tab[t];
                    src_ip = ~src_ip_tab[t];
                end
                if (tx_en === 1'b1) begin
                    en_seen = 1'b1;
                end
                if (en_seen && tx_en !== 1'b1 && fall_cycle < 0) begin
                    fall_cycle = cycle_count;
                end else if (fall_cycle >= 0 && tx_en === 1'b1) begin
                    note_failure("tx_en went high again before ready returned");
                end
            end
            if (fall_cycle < 0) begin
                note_failure("ready returned without a transmitted frame");
            end else if (cycle_count - fall_cycle < GAP_TICKS * DIVIDER) begin
                note_failure($sformatf("interframe gap only %0d cycles",
                    cycle_count - fall_cycle));
            end
            check_frame(t, base);
            $display("test %0d: %0d checks, %0d errors", t,
                check_count - checks_before, error_count - errors_before);
        end
        // Long enough for a stray frame to show up on tx_en
        repeat (PREAMBLE_NIBBLES * DIVIDER * 2) next_cycle();
        check_value("frames_seen", 32'(frames_seen), 32'(NUM_TESTS));
        $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, check_count, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/tb_clock_gen.sv
`default_nettype none

// Free-running clock for the testbench, low for the first half period
module tb_clock_gen #(
    parameter int PERIOD = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always begin
        #(PERIOD / 2);
        clk = ~clk;
    end

endmodule

`default_nettype wire

//--- rtl/udp_eth_tx.sv
`default_nettype none

// UDP over IPv4 transmitter on a 10/100 MII transmit path
module udp_eth_tx import udp_tx_pkg::*; #(
    parameter int DATA_BYTES = 18,
    parameter int DIVIDER = 4
) (
    input logic clk,
    input logic reset,
    input logic send,
    input logic [8*DATA_BYTES-1:0] payload,
    input mac_addr_t src_mac,
    input mac_addr_t dest_mac,
    input ip_addr_t src_ip,
    input ip_addr_t dest_ip,
    input udp_port_t src_port,
    input udp_port_t dest_port,
    output logic ready,
    output logic tx_en,
    output nibble_t tx_d
);

    logic tick;

    frame_if frame_bus ();
    crc_if crc_bus ();

    // Nibble-rate enable derived from the system clock
    tx_tick_gen #(
        .DIVIDER(DIVIDER)
    ) u_tick_gen (
        .clk(clk),
        .reset(reset),
        .tick(tick)
    );

    udp_frame_builder #(
        .DATA_BYTES(DATA_BYTES)
    ) u_builder (
        .clk(clk),
        .reset(reset),
        .send(send),
        .payload(payload),
        .src_mac(src_mac),
        .dest_mac(dest_mac),
        .src_ip(src_ip),
        .dest_ip(dest_ip),
        .src_port(src_port),
        .dest_port(dest_port),
        .ready(ready),
        .frame(frame_bus.builder)
    );

    mii_tx_sequencer #(
        .DATA_BYTES(DATA_BYTES)
    ) u_sequencer (
        .clk(clk),
        .reset(reset),
        .tick(tick),
        .frame(frame_bus.sequencer),
        .fcs(crc_bus.sequencer),
        .tx_en(tx_en),
        .tx_d(tx_d)
    );

    eth_fcs_crc32 u_fcs (
        .clk(clk),
        .reset(reset),
        .fcs(crc_bus.crc_unit)
    );

endmodule

`default_nettype wire

//--- rtl/mii_tx_sequencer.sv
`default_nettype none

// Drives the MII transmit nibbles for one frame per request
module mii_tx_sequencer import udp_tx_pkg::*; #(
    parameter int DATA_BYTES = 18
) (
    input logic clk,
    input logic reset,
    input logic tick,
    frame_if.sequencer frame,
    crc_if.sequencer fcs,
    output logic tx_en,
    output nibble_t tx_d
);

    localparam int FRAME_NIBBLES = 2 * (FRAME_HEADER_BYTES + DATA_BYTES);
    localparam int FCS_NIBBLES = 2 * FCS_BYTES;

    // Wide enough for the longest frame in nibbles
    localparam int COUNT_W = 11;

    typedef enum logic [2:0] {IDLE, PREAMBLE, FRAME, FCS, GAP} tx_state_t;

    tx_state_t state;
    logic [COUNT_W-1:0] count;
    nibble_t frame_nibble;
    nibble_t fcs_nibble;
    crc_t fcs_word;

    // Two nibbles per octet, so the octet index is the count without its low bit
    assign frame.byte_index = count[COUNT_W-1:1];

    // Low nibble of each octet goes first
    assign frame_nibble = count[0] ? frame.byte_data[7:4] : frame.byte_data[3:0];

    // FCS is the complemented CRC, least significant nibble first
    assign fcs_word = ~fcs.crc;
    assign fcs_nibble = fcs_word[4*count[2:0] +: 4];

    // Every frame nibble that goes on the wire also goes into the CRC
    assign fcs.crc_clear = tick && (state == IDLE) && frame.frame_valid;
    assign fcs.nibble_valid = tick && (state == FRAME);
    assign fcs.nibble = frame_nibble;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            count <= '0;
            tx_en <= 1'b0;
            tx_d <= '0;
            frame.frame_done <= 1'b0;
        end else begin
            frame.frame_done <= 1'b0;
            if (tick) begin
                case (state)
                    IDLE: if (frame.frame_valid) begin
                        // First preamble nibble goes out on the same tick
                        tx_en <= 1'b1;
                        tx_d <= PREAMBLE_NIBBLE;
                        count <= COUNT_W'(1);
                        state <= PREAMBLE;
                    end
                    PREAMBLE: begin
                        if (count == COUNT_W'(PREAMBLE_NIBBLES - 1)) begin
                            tx_d <= SFD_NIBBLE;
                            count <= '0;
                            state <= FRAME;
                        end else begin
                            tx_d <= PREAMBLE_NIBBLE;
                            count <= count + 1'b1;
                        end
                    end
                    FRAME: begin
                        tx_d <= frame_nibble;
                        if (count == COUNT_W'(FRAME_NIBBLES - 1)) begin
                            count <= '0;
                            state <= FCS;
                        end else begin
                            count <= count + 1'b1;
                        end
                    end
                    FCS: begin
                        // The tick after the last FCS nibble is the first gap tick
                        if (count == COUNT_W'(FCS_NIBBLES)) begin
                            tx_en <= 1'b0;
                            tx_d <= '0;
                            count <= COUNT_W'(1);
                            state <= GAP;
                        end else begin
                            tx_d <= fcs_nibble;
                            count <= count + 1'b1;
                        end
                    end
                    GAP: begin
                        if (count == COUNT_W'(GAP_TICKS)) begin
                            frame.frame_done <= 1'b1;
                            count <= '0;
                            state <= IDLE;
                        end else begin
                            count <= count + 1'b1;
                        end
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    // Line stays quiet outside of the preamble, frame and FCS
    assert property (@(posedge clk) disable iff (reset)
        (state == IDLE || state == GAP) |-> !tx_en)
        else $error("tx_en high while idle or in the gap");

    // The builder must keep the frame steady until this side releases it
    assert property (@(posedge clk) disable iff (reset) (state != IDLE) |-> frame.frame_valid)
        else $error("Frame withdrawn during transmission");

endmodule

`default_nettype wire

//--- rtl/eth_fcs_crc32.sv
`default_nettype none

// Ethernet FCS, a CRC-32 built up four bits at a time in MII order
module eth_fcs_crc32 import udp_tx_pkg::*; (
    input logic clk,
    input logic reset,
    crc_if.crc_unit fcs
);

    // Bit 0 of the nibble is the first bit on the wire, so it meets bit 0 of the CRC
    function automatic crc_t crc_nibble(input crc_t crc_in, input nibble_t data);
        crc_t c;
        c = crc_in ^ {28'h0, data};
        for (int i = 0; i < 4; i++) begin
            c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
        end
        return c;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            fcs.crc <= CRC_INIT;
        end else if (fcs.crc_clear) begin
            // A new frame starts from all ones
            fcs.crc <= CRC_INIT;
        end else if (fcs.nibble_valid) begin
            fcs.crc <= crc_nibble(fcs.crc, fcs.nibble);
        end
    end

    // Clearing and feeding in the same cycle would lose a nibble
    assert property (@(posedge clk) disable iff (reset) !(fcs.crc_clear && fcs.nibble_valid))
        else $error("CRC clear and nibble update in the same cycle");

endmodule

`default_nettype wire

//--- rtl/udp_frame_builder.sv
`default_nettype none

// Captures a send request and serves the finished frame octet by octet
module udp_frame_builder import udp_tx_pkg::*; #(
    parameter int DATA_BYTES = 18
) (
    input logic clk,
    input logic reset,
    input logic send,
    input logic [8*DATA_BYTES-1:0] payload,
    input mac_addr_t src_mac,
    input mac_addr_t dest_mac,
    input ip_addr_t src_ip,
    input ip_addr_t dest_ip,
    input udp_port_t src_port,
    input udp_port_t dest_port,
    output logic ready,
    frame_if.builder frame
);

    localparam int FRAME_BYTES = FRAME_HEADER_BYTES + DATA_BYTES;

    // Length fields are fixed by the payload size
    localparam logic [15:0] IP_TOTAL_LEN = 16'(IP_HEADER_BYTES + UDP_HEADER_BYTES + DATA_BYTES);
    localparam logic [15:0] UDP_LEN = 16'(UDP_HEADER_BYTES + DATA_BYTES);

    typedef enum logic [1:0] {IDLE, CAPTURE, CHECKSUM, HOLD} build_state_t;

    build_state_t state;
    logic send_prev;
    logic start;

    // Held copy of the request
    logic [8*DATA_BYTES-1:0] payload_q;
    mac_addr_t src_mac_q;
    mac_addr_t dest_mac_q;
    ip_addr_t src_ip_q;
    ip_addr_t dest_ip_q;
    udp_port_t src_port_q;
    udp_port_t dest_port_q;

    logic [19:0] header_sum;
    logic [19:0] ip_sum_q;
    logic [16:0] fold_once;
    logic [15:0] fold_twice;
    logic [15:0] ip_checksum_q;
    logic [8*FRAME_HEADER_BYTES-1:0] header_octets;

    // Only a rising edge of send counts, and only while idle
    assign start = send && !send_prev && ready;

    // Identification, flags and offset words are zero and add nothing to the sum
    assign header_sum = 20'({IP_VERSION_IHL, IP_TOS}) + 20'(IP_TOTAL_LEN)
        + 20'({IP_TTL, IP_PROTO_UDP}) + 20'(src_ip_q[31:16]) + 20'(src_ip_q[15:0])
        + 20'(dest_ip_q[31:16]) + 20'(dest_ip_q[15:0]);

    // Two end-around carry folds are enough for eight 16-bit words
    assign fold_once = 17'(ip_sum_q[15:0]) + 17'(ip_sum_q[19:16]);
    assign fold_twice = fold_once[15:0] + 16'(fold_once[16]);

    // Header octets in wire order, first octet in the top bits
    assign header_octets = {dest_mac_q, src_mac_q, ETHER_TYPE_IPV4,
        IP_VERSION_IHL, IP_TOS, IP_TOTAL_LEN, 16'h0000, 16'h0000,
        IP_TTL, IP_PROTO_UDP, ip_checksum_q, src_ip_q, dest_ip_q,
        src_port_q, dest_port_q, UDP_LEN, 16'h0000};

    always_comb begin : select_octet
        int idx;
        idx = int'(frame.byte_index);
        if (idx < FRAME_HEADER_BYTES) begin
            frame.byte_data = header_octets[8*(FRAME_HEADER_BYTES-1-idx) +: 8];
        end else if (idx < FRAME_BYTES) begin
            // The payload's most significant octet goes out first
            frame.byte_data = payload_q[8*(FRAME_BYTES-1-idx) +: 8];
        end else begin
            frame.byte_data = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            send_prev <= 1'b1;
            ready <= 1'b1;
            frame.frame_valid <= 1'b0;
        end else begin
            send_prev <= send;
            case (state)
                IDLE: if (start) begin
                    ready <= 1'b0;
                    state <= CAPTURE;
                end
                CAPTURE: state <= CHECKSUM;
                CHECKSUM: begin
                    frame.frame_valid <= 1'b1;
                    state <= HOLD;
                end
                HOLD: if (frame.frame_done) begin
                    // The sequencer has finished the gap so a new request may come in
                    frame.frame_valid <= 1'b0;
                    ready <= 1'b1;
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            payload_q <= payload;
            src_mac_q <= src_mac;
            dest_mac_q <= dest_mac;
            src_ip_q <= src_ip;
            dest_ip_q <= dest_ip;
            src_port_q <= src_port;
            dest_port_q <= dest_port;
        end
        if (state == CAPTURE) begin
            ip_sum_q <= header_sum;
        end
        if (state == CHECKSUM) begin
            ip_checksum_q <= ~fold_twice;
        end
    end

    // The sequencer may only release a frame it was handed
    assert property (@(posedge clk) disable iff (reset) frame.frame_done |-> frame.frame_valid)
        else $error("frame_done seen without a valid frame");

endmodule

`default_nettype wire

//--- rtl/tx_tick_gen.sv
`default_nettype none

// Divides clk down to one enable pulse per MII nibble time
module tx_tick_gen #(
    parameter int DIVIDER = 4
) (
    input logic clk,
    input logic reset,
    output logic tick
);

    // One spare bit keeps the counter at least one bit wide
    localparam int COUNT_W = $clog2(DIVIDER + 1);

    logic [COUNT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
            tick <= 1'b0;
        end else begin
            // Tick follows the wrap by one cycle, so it is a clean register output
            tick <= (count == COUNT_W'(DIVIDER - 1));
            count <= (count == COUNT_W'(DIVIDER - 1)) ? '0 : count + 1'b1;
        end
    end

    // Back-to-back ticks only happen when DIVIDER is below 2
    assert property (@(posedge clk) disable iff (reset) tick |=> !tick)
        else $error("DIVIDER must be at least 2");

endmodule

`default_nettype wire

//--- rtl/udp_tx_ifs.sv
`default_nettype none

// Frame handoff from the builder to the sequencer
// The sequencer reads octets by index and gets them back in the same cycle
interface frame_if;
    logic frame_valid;
    logic [9:0] byte_index;
    logic [7:0] byte_data;
    logic frame_done;

    modport builder (
        output frame_valid,
        output byte_data,
        input byte_index,
        input frame_done
    );

    modport sequencer (
        input frame_valid,
        input byte_data,
        output byte_index,
        output frame_done
    );
endinterface

// Nibble feed from the sequencer into the running FCS
interface crc_if;
    logic crc_clear;
    logic nibble_valid;
    logic [3:0] nibble;
    logic [31:0] crc;

    modport sequencer (output crc_clear, output nibble_valid, output nibble, input crc);
    modport crc_unit (input crc_clear, input nibble_valid, input nibble, output crc);
endinterface

`default_nettype wire

//--- rtl/udp_tx_pkg.sv
`default_nettype none

// Shared types and constants for the UDP over IPv4 Ethernet transmitter
package udp_tx_pkg;

    // Addressing fields as they appear in the headers
    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;

    // Data units on the frame and on the MII lines
    typedef logic [7:0] octet_t;
    typedef logic [3:0] nibble_t;

    // Running CRC-32 register
    typedef logic [31:0] crc_t;

    // Octet position in a frame, wide enough for 550 octets
    typedef logic [9:0] byte_index_t;

    // Header and trailer lengths in octets
    localparam int ETH_HEADER_BYTES = 14;
    localparam int IP_HEADER_BYTES = 20;
    localparam int UDP_HEADER_BYTES = 8;
    localparam int FCS_BYTES = 4;

    // All three headers together, ahead of the payload
    localparam int FRAME_HEADER_BYTES = ETH_HEADER_BYTES + IP_HEADER_BYTES + UDP_HEADER_BYTES;

    // Preamble plus SFD, counted in nibbles
    localparam int PREAMBLE_NIBBLES = 16;

    // Interframe gap in ticks, which is 12 octet times on MII
    localparam int GAP_TICKS = 24;

    // Ethernet type field for an IPv4 datagram
    localparam logic [15:0] ETHER_TYPE_IPV4 = 16'h0800;

    // Version 4 with a five-word header and no options
    localparam octet_t IP_VERSION_IHL = 8'h45;

    // Type of service asks for high throughput and reliability
    localparam octet_t IP_TOS = 8'h0C;
    localparam octet_t IP_TTL = 8'hFF;

    // Next level protocol is UDP
    localparam octet_t IP_PROTO_UDP = 8'h11;

    // CRC-32 in its reflected form, shifted out towards bit 0
    localparam crc_t CRC_POLY = 32'hEDB88320;
    localparam crc_t CRC_INIT = 32'hFFFFFFFF;

    // Preamble nibbles are 0x5 and the SFD closes with 0xD
    localparam nibble_t PREAMBLE_NIBBLE = 4'h5;
    localparam nibble_t SFD_NIBBLE = 4'hD;

endpackage

`default_nettype wire
